// File: verilog/aud_pkg.sv
`default_nettype none

package aud_pkg;

    localparam int BCLK_HALF         = 4;  // i_clk cycles per bclk half period
    localparam int SLOTS_PER_CHANNEL = 16; // bclk periods per lrck half
    localparam int SAMPLE_W          = 16;
    localparam int ADDR_W            = 20;
    localparam int SPEED_W           = 4;

    localparam int BCLK_CNT_W = $clog2(BCLK_HALF);
    localparam int SLOT_CNT_W = $clog2(SLOTS_PER_CHANNEL);
    localparam int BIT_CNT_W  = $clog2(SAMPLE_W + 1);

    localparam logic [BCLK_CNT_W-1:0] BCLK_HALF_LAST = BCLK_CNT_W'(BCLK_HALF - 1);
    localparam logic [SLOT_CNT_W-1:0] SLOT_LAST      = SLOT_CNT_W'(SLOTS_PER_CHANNEL - 1);
    localparam logic [BIT_CNT_W-1:0]  SAMPLE_BITS    = BIT_CNT_W'(SAMPLE_W);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PLAY,
        ST_PAUSE
    } play_state_t;

    // value * (1/speed), reciprocals in Q16
    function automatic logic [SAMPLE_W-1:0] div_by_speed(
        input logic [SAMPLE_W-1:0] value,
        input logic [SPEED_W-1:0]  speed
    );
        logic [SAMPLE_W-1:0]   recip;
        logic [2*SAMPLE_W-1:0] prod;
        begin
            case (speed)
                4'd2:    recip = 16'h8000; // exact halving
                4'd3:    recip = 16'h5555;
                4'd4:    recip = 16'h4000;
                4'd5:    recip = 16'h3333;
                4'd6:    recip = 16'h2AAA;
                4'd7:    recip = 16'h2492;
                4'd8:    recip = 16'h2000;
                4'd9:    recip = 16'h1C71;
                4'd10:   recip = 16'h1999;
                4'd11:   recip = 16'h1745;
                4'd12:   recip = 16'h1555;
                4'd13:   recip = 16'h13B1;
                4'd14:   recip = 16'h1249;
                4'd15:   recip = 16'h1111;
                default: recip = '0;       // speed 0 and 1 pass through
            endcase
            prod = value * recip;
            if (speed <= 4'd1) begin
                div_by_speed = value;
            end else begin
                div_by_speed = prod[2*SAMPLE_W-1:SAMPLE_W];
            end
        end
    endfunction

endpackage

`default_nettype wire

// File: verilog/aud_clk_gen.sv
`default_nettype none

module aud_clk_gen (
    input  logic i_clk,
    input  logic i_rst_n,
    output logic o_bclk,
    output logic o_daclrck,
    output logic o_frame_stb,
    output logic o_bclk_fall
);

    logic [aud_pkg::BCLK_CNT_W-1:0] div_cnt;
    logic [aud_pkg::SLOT_CNT_W-1:0] slot_cnt;
    logic                           half_end;
    logic                           fall_now;
    logic                           slot_end;

    assign half_end = (div_cnt == aud_pkg::BCLK_HALF_LAST);
    assign fall_now = half_end && o_bclk;                 // bclk goes low at this edge
    assign slot_end = (slot_cnt == aud_pkg::SLOT_LAST);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            div_cnt <= '0;
        end else if (half_end) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_bclk      <= 1'b0;
            o_daclrck   <= 1'b1;                          // start in the right half
            slot_cnt    <= '0;
            o_bclk_fall <= 1'b0;
            o_frame_stb <= 1'b0;
        end else begin
            o_bclk_fall <= fall_now;
            o_frame_stb <= fall_now && slot_end && o_daclrck;
            if (half_end) begin
                o_bclk <= ~o_bclk;
            end
            if (fall_now) begin
                if (slot_end) begin
                    slot_cnt  <= '0;
                    o_daclrck <= ~o_daclrck;              // lrck moves on a bclk fall
                end else begin
                    slot_cnt <= slot_cnt + 1'b1;
                end
            end
        end
    end

    // the frame strobe marks the left half and lines up with a bclk fall
    a_frame_on_lrck_fall : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_frame_stb |-> $fell(o_daclrck) && o_bclk_fall
    ) else $error("frame strobe not at left half start");

endmodule

`default_nettype wire

// File: verilog/aud_dsp.sv
`default_nettype none

module aud_dsp (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_start,
    input  logic                         i_pause,
    input  logic                         i_stop,
    input  logic                         i_fast,          // 1 skips samples, 0 repeats them
    input  logic                         i_interpolation, // slow mode: 0 hold, 1 linear
    input  logic                         i_frame_stb,
    input  logic [aud_pkg::SPEED_W-1:0]  i_speed,
    input  logic [aud_pkg::SAMPLE_W-1:0] i_sram_data,
    output logic [aud_pkg::ADDR_W-1:0]   o_sram_addr,
    output logic [aud_pkg::SAMPLE_W-1:0] o_sample
);

    aud_pkg::play_state_t state;

    logic [aud_pkg::ADDR_W-1:0]   addr;
    logic [aud_pkg::ADDR_W-1:0]   step_size;
    logic [aud_pkg::SAMPLE_W-1:0] prev_data;
    logic [aud_pkg::SAMPLE_W-1:0] out_data;
    logic [aud_pkg::SAMPLE_W-1:0] prev_part;
    logic [aud_pkg::SAMPLE_W-1:0] next_part;
    logic [aud_pkg::SAMPLE_W-1:0] blend;
    logic [aud_pkg::SPEED_W-1:0]  speed_eff;
    logic [aud_pkg::SPEED_W-1:0]  speed_last;
    logic [aud_pkg::SPEED_W-1:0]  weight_prev;
    logic [aud_pkg::SPEED_W-1:0]  interp_cnt;
    logic                         slot_end;
    logic                         load_first;
    logic                         play_step;
    logic                         addr_step;
    logic                         stop_now;

    assign speed_eff   = (i_speed == '0) ? {{(aud_pkg::SPEED_W-1){1'b0}}, 1'b1} : i_speed;
    assign speed_last  = speed_eff - 1'b1;
    assign weight_prev = speed_eff - interp_cnt;
    assign slot_end    = (interp_cnt >= speed_last);      // last repeat of this sample

    // fast mode jumps by the speed, slow mode walks one word at a time
    assign step_size = i_fast
                     ? {{(aud_pkg::ADDR_W-aud_pkg::SPEED_W){1'b0}}, speed_eff}
                     : {{(aud_pkg::ADDR_W-1){1'b0}}, 1'b1};

    assign load_first = (state == aud_pkg::ST_IDLE) && i_start;
    assign stop_now   = (state != aud_pkg::ST_IDLE) && i_stop;
    assign play_step  = (state == aud_pkg::ST_PLAY) && !i_stop && !i_pause && i_frame_stb;
    assign addr_step  = play_step && (i_fast || slot_end);

    // linear blend between the held word and the one at the current address
    assign prev_part = aud_pkg::div_by_speed(prev_data, speed_eff);
    assign next_part = aud_pkg::div_by_speed(i_sram_data, speed_eff);
    assign blend     = prev_part * weight_prev + next_part * interp_cnt;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= aud_pkg::ST_IDLE;
            addr       <= '0;
            interp_cnt <= '0;
        end else begin
            case (state)
                aud_pkg::ST_IDLE: begin
                    if (i_start) begin
                        state      <= aud_pkg::ST_PLAY;
                        addr       <= step_size;          // word 0 is taken now
                        interp_cnt <= '0;
                    end
                end
                aud_pkg::ST_PLAY: begin
                    if (i_stop) begin
                        state <= aud_pkg::ST_IDLE;
                        addr  <= '0;
                    end else if (i_pause) begin
                        state <= aud_pkg::ST_PAUSE;
                    end else if (i_frame_stb) begin
                        if (i_fast || slot_end) begin
                            addr       <= addr + step_size;
                            interp_cnt <= '0;
                        end else begin
                            interp_cnt <= interp_cnt + 1'b1;
                        end
                    end
                end
                aud_pkg::ST_PAUSE: begin
                    if (i_stop) begin
                        state <= aud_pkg::ST_IDLE;
                        addr  <= '0;
                    end else if (!i_pause) begin
                        state <= aud_pkg::ST_PLAY;
                    end
                end
                default: begin
                    state <= aud_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (load_first || addr_step) begin
            prev_data <= i_sram_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            out_data <= '0;
        end else if (stop_now) begin
            out_data <= '0;                               // silence once stopped
        end else if (play_step) begin
            if (i_fast || !i_interpolation) begin
                out_data <= prev_data;
            end else begin
                out_data <= blend;
            end
        end
    end

    assign o_sram_addr = addr;
    assign o_sample    = out_data;

    a_addr_cause : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !$stable(addr) |-> $past(i_frame_stb || i_start || i_stop)
    ) else $error("address moved without strobe, start or stop");

    a_interp_bound : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (play_step && !i_fast) |=> (interp_cnt < $past(speed_eff))
    ) else $error("interpolation count reached the speed");

endmodule

`default_nettype wire

// File: verilog/aud_dac_serializer.sv
`default_nettype none

module aud_dac_serializer (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_frame_stb,
    input  logic                         i_bclk_fall,
    input  logic [aud_pkg::SAMPLE_W-1:0] i_sample,
    output logic                         o_dacdat
);

    logic                          load_pend;
    logic                          load;
    logic [aud_pkg::SAMPLE_W-1:0]  shreg;
    logic [aud_pkg::BIT_CNT_W-1:0] bit_cnt;  // bits already put on o_dacdat

    // the frame strobe normally arrives with a bclk fall, so the msb is on the
    // line before the first bclk rise of the left half; otherwise it waits
    assign load = i_bclk_fall && (i_frame_stb || load_pend);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            load_pend <= 1'b0;
        end else if (i_frame_stb && !i_bclk_fall) begin
            load_pend <= 1'b1;
        end else if (i_bclk_fall) begin
            load_pend <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (load) begin
            shreg <= {i_sample[aud_pkg::SAMPLE_W-2:0], 1'b0};
        end else if (i_bclk_fall) begin
            shreg <= {shreg[aud_pkg::SAMPLE_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dacdat <= 1'b0;
            bit_cnt  <= aud_pkg::SAMPLE_BITS;               // nothing to send
        end else if (load) begin
            o_dacdat <= i_sample[aud_pkg::SAMPLE_W-1];     // msb first
            bit_cnt  <= {{(aud_pkg::BIT_CNT_W-1){1'b0}}, 1'b1};
        end else if (i_bclk_fall) begin
            if (bit_cnt < aud_pkg::SAMPLE_BITS) begin
                o_dacdat <= shreg[aud_pkg::SAMPLE_W-1];
                bit_cnt  <= bit_cnt + 1'b1;
            end else begin
                o_dacdat <= 1'b0;                          // pad the rest of the frame
            end
        end
    end

    a_bit_cnt_range : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        bit_cnt <= aud_pkg::SAMPLE_BITS
    ) else $error("bit counter past sample width");

endmodule

`default_nettype wire

// File: verilog/aud_top.sv
`default_nettype none

module aud_top (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_start,
    input  logic                         i_pause,
    input  logic                         i_stop,
    input  logic                         i_fast,
    input  logic                         i_interpolation,
    input  logic [aud_pkg::SPEED_W-1:0]  i_speed,
    input  logic [aud_pkg::SAMPLE_W-1:0] i_sram_data,
    output logic [aud_pkg::ADDR_W-1:0]   o_sram_addr,
    output logic                         o_bclk,
    output logic                         o_daclrck,
    output logic                         o_dacdat
);

    logic                         frame_stb;
    logic                         bclk_fall;
    logic [aud_pkg::SAMPLE_W-1:0] sample;     // held for a whole frame

    aud_clk_gen u_clk_gen (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .o_bclk      (o_bclk),
        .o_daclrck   (o_daclrck),
        .o_frame_stb (frame_stb),
        .o_bclk_fall (bclk_fall)
    );

    aud_dsp u_dsp (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_pause         (i_pause),
        .i_stop          (i_stop),
        .i_fast          (i_fast),
        .i_interpolation (i_interpolation),
        .i_frame_stb     (frame_stb),
        .i_speed         (i_speed),
        .i_sram_data     (i_sram_data),
        .o_sram_addr     (o_sram_addr),
        .o_sample        (sample)
    );

    aud_dac_serializer u_serializer (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_frame_stb (frame_stb),
        .i_bclk_fall (bclk_fall),
        .i_sample    (sample),
        .o_dacdat    (o_dacdat)
    );

endmodule

`default_nettype wire

// File: test/tb_sram_model.sv
`default_nettype none

module tb_sram_model (
    input  logic [aud_pkg::ADDR_W-1:0]   i_addr,
    output logic [aud_pkg::SAMPLE_W-1:0] o_data
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] full;

    // read-only and asynchronous, data follows the address at once
    assign full   = i_addr * 32'd977 + 32'd5;
    assign o_data = full[aud_pkg::SAMPLE_W-1:0];

endmodule

`default_nettype wire

// File: test/tb_aud_top.sv
`default_nettype none

module tb_aud_top;

    timeunit 1ns;
    timeprecision 100ps;

    logic                         i_clk;
    logic                         i_rst_n;
    logic                         i_start;
    logic                         i_pause;
    logic                         i_stop;
    logic                         i_fast;
    logic                         i_interpolation;
    logic [aud_pkg::SPEED_W-1:0]  i_speed;
    logic [aud_pkg::SAMPLE_W-1:0] sram_data;
    logic [aud_pkg::ADDR_W-1:0]   o_sram_addr;
    logic                         o_bclk;
    logic                         o_daclrck;
    logic                         o_dacdat;

    logic [aud_pkg::SAMPLE_W-1:0] rx_shift;
    int                           rx_cnt = 0;
    logic [aud_pkg::SAMPLE_W-1:0] rx_words[$];   // left channel words off the serial line

    int test_errs   = 0;
    int total_errs  = 0;
    int tests_run   = 0;
    int tests_failed = 0;

    aud_top UUT (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_pause         (i_pause),
        .i_stop          (i_stop),
        .i_fast          (i_fast),
        .i_interpolation (i_interpolation),
        .i_speed         (i_speed),
        .i_sram_data     (sram_data),
        .o_sram_addr     (o_sram_addr),
        .o_bclk          (o_bclk),
        .o_daclrck       (o_daclrck),
        .o_dacdat        (o_dacdat)
    );

    tb_sram_model u_sram (
        .i_addr (o_sram_addr),
        .o_data (sram_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // DAC side, msb first on bclk rise while lrck is low
    always @(posedge o_bclk) begin
        if (!o_daclrck) begin
            rx_shift = {rx_shift[aud_pkg::SAMPLE_W-2:0], o_dacdat};
            rx_cnt   = rx_cnt + 1;
            if (rx_cnt == aud_pkg::SAMPLE_W) begin
                rx_words.push_back(rx_shift);
                rx_cnt = 0;
            end
        end else begin
            rx_cnt = 0;
        end
    end

    function automatic logic [aud_pkg::SAMPLE_W-1:0] sram_word(input int unsigned addr);
        logic [31:0] full;
        full = addr * 977 + 5;
        return full[aud_pkg::SAMPLE_W-1:0];
    endfunction

    // output produced by the k-th frame of play since start
    function automatic logic [aud_pkg::SAMPLE_W-1:0] expected_word(
        input int k,
        input logic fast,
        input int speed,
        input logic interp
    );
        int                           s;
        int                           j;
        int                           c;
        logic [aud_pkg::SPEED_W-1:0]  spd;
        logic [aud_pkg::SAMPLE_W-1:0] p;
        logic [aud_pkg::SAMPLE_W-1:0] n;
        logic [31:0]                  mix;
        s = (speed == 0) ? 1 : speed;
        if (fast) begin
            return sram_word((k - 1) * s);
        end
        j = (k - 1) / s;                   // word index
        c = (k - 1) % s;                   // repeat within that word
        if (!interp) begin
            return sram_word(j);
        end
        spd = s[aud_pkg::SPEED_W-1:0];
        p   = aud_pkg::div_by_speed(sram_word(j), spd);
        n   = aud_pkg::div_by_speed(sram_word(j + 1), spd);
        mix = p * (s - c) + n * c;
        return mix[aud_pkg::SAMPLE_W-1:0];
    endfunction

    // SRAM address once k frames of play have passed
    function automatic int expected_addr(input int k, input logic fast, input int speed);
        int s;
        s = (speed == 0) ? 1 : speed;
        if (fast) begin
            return (k + 1) * s;
        end
        return 1 + k / s;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED %s: expected 0x%0h, actual 0x%0h", what, expected, actual);
        test_errs  = test_errs + 1;
        total_errs = total_errs + 1;
    endtask

    task automatic end_test(input string name);
        tests_run = tests_run + 1;
        if (test_errs != 0) begin
            tests_failed = tests_failed + 1;
        end
        $display("test %s finished with %0d errors", name, test_errs);
        test_errs = 0;
    endtask

    task automatic get_word(output logic [aud_pkg::SAMPLE_W-1:0] word);
        int waited;
        int limit;
        waited = 0;
        limit  = 3 * 4 * aud_pkg::BCLK_HALF * aud_pkg::SLOTS_PER_CHANNEL; // three frames
        while (rx_words.size() == 0 && waited < limit) begin
            @(negedge i_clk);
            waited = waited + 1;
        end
        if (rx_words.size() == 0) begin
            $display("timeout: no word came out of the DAC serial line in %0d cycles", limit);
            $display("** FAIL **");
            $finish;
        end else begin
            word = rx_words.pop_front();
        end
    endtask

    // start just after a word ends, the next word still carries the old sample
    task automatic start_play();
        logic [aud_pkg::SAMPLE_W-1:0] dummy;
        rx_words.delete();
        get_word(dummy);
        @(posedge i_clk);
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        get_word(dummy);
    endtask

    task automatic stop_play(input string name);
        @(posedge i_clk);
        i_stop <= 1'b1;
        @(posedge i_clk);
        i_stop <= 1'b0;
        @(negedge i_clk);
        if (o_sram_addr !== '0) report_mismatch({name, " addr after stop"}, 0, o_sram_addr);
    endtask

    task automatic test_reset();
        logic [aud_pkg::SAMPLE_W-1:0] word;
        @(negedge i_clk);
        if (o_sram_addr !== '0) report_mismatch("reset addr", 0, o_sram_addr);
        if (UUT.u_dsp.state !== aud_pkg::ST_IDLE) begin
            report_mismatch("reset state", aud_pkg::ST_IDLE, UUT.u_dsp.state);
        end
        rx_words.delete();
        repeat (2) begin
            get_word(word);
            if (word !== '0) report_mismatch("reset word", 0, word);
        end
        end_test("reset");
    endtask

    // one frame is 256 cycles, lrck high for 128 of them, 32 bclk periods
    task automatic test_clocks();
        int   limit;
        int   waited;
        int   frame_cycles;
        int   lrck_high;
        int   bclk_rises;
        logic lrck_prev;
        logic bclk_prev;
        limit  = 2 * 4 * aud_pkg::BCLK_HALF * aud_pkg::SLOTS_PER_CHANNEL; // two frames
        waited = 0;
        @(negedge i_clk);
        lrck_prev = o_daclrck;
        @(negedge i_clk);
        while (!(lrck_prev && !o_daclrck) && waited < limit) begin
            lrck_prev = o_daclrck;
            @(negedge i_clk);
            waited = waited + 1;
        end
        if (!(lrck_prev && !o_daclrck)) begin
            $display("clocks: the left/right clock never fell within %0d cycles", limit);
            test_errs  = test_errs + 1;
            total_errs = total_errs + 1;
        end else begin
            frame_cycles = 0;
            lrck_high    = 0;
            bclk_rises   = 0;
            do begin
                lrck_prev = o_daclrck;
                bclk_prev = o_bclk;
                @(negedge i_clk);
                frame_cycles = frame_cycles + 1;
                if (o_daclrck) lrck_high = lrck_high + 1;
                if (o_bclk && !bclk_prev) bclk_rises = bclk_rises + 1;
            end while (!(lrck_prev && !o_daclrck) && frame_cycles < limit);
            if (frame_cycles != 256) report_mismatch("clocks frame length", 256, frame_cycles);
            if (lrck_high != 128) report_mismatch("clocks lrck high", 128, lrck_high);
            if (bclk_rises != 32) report_mismatch("clocks bclk periods", 32, bclk_rises);
        end
        end_test("clocks");
    endtask

    task automatic run_playback(input string name, input logic fast,
                                input logic [aud_pkg::SPEED_W-1:0] speed,
                                input logic interp, input int nwords);
        logic [aud_pkg::SAMPLE_W-1:0] word;
        logic [aud_pkg::SAMPLE_W-1:0] exp_word;
        @(posedge i_clk);
        i_fast          <= fast;
        i_speed         <= speed;
        i_interpolation <= interp;
        start_play();
        for (int k = 1; k <= nwords; k++) begin
            get_word(word);
            exp_word = expected_word(k, fast, speed, interp);
            if (word !== exp_word) report_mismatch({name, " word"}, exp_word, word);
            // word k goes out while frame k+1 has already stepped the address
            if (o_sram_addr !== expected_addr(k + 1, fast, speed)) begin
                report_mismatch({name, " addr"}, expected_addr(k + 1, fast, speed), o_sram_addr);
            end
        end
        stop_play(name);
        end_test(name);
    endtask

    task automatic test_pause_stop();
        logic [aud_pkg::SAMPLE_W-1:0] word;
        @(posedge i_clk);
        i_fast          <= 1'b1;
        i_speed         <= 4'd1;
        i_interpolation <= 1'b0;
        start_play();
        for (int k = 1; k <= 3; k++) begin
            get_word(word);
            if (word !== expected_word(k, 1'b1, 1, 1'b0)) begin
                report_mismatch("pause_stop word", expected_word(k, 1'b1, 1, 1'b0), word);
            end
        end
        @(posedge i_clk);
        i_pause <= 1'b1;
        repeat (3) begin                   // frame 4 is the last one before the hold
            get_word(word);
            if (word !== expected_word(4, 1'b1, 1, 1'b0)) begin
                report_mismatch("pause_stop held word", expected_word(4, 1'b1, 1, 1'b0), word);
            end
            if (o_sram_addr !== expected_addr(4, 1'b1, 1)) begin
                report_mismatch("pause_stop held addr", expected_addr(4, 1'b1, 1), o_sram_addr);
            end
        end
        @(posedge i_clk);
        i_pause <= 1'b0;
        get_word(word);
        if (word !== expected_word(4, 1'b1, 1, 1'b0)) begin
            report_mismatch("pause_stop resume word", expected_word(4, 1'b1, 1, 1'b0), word);
        end
        get_word(word);
        if (word !== expected_word(5, 1'b1, 1, 1'b0)) begin
            report_mismatch("pause_stop resume word", expected_word(5, 1'b1, 1, 1'b0), word);
        end
        stop_play("pause_stop");
        repeat (2) begin
            get_word(word);
            if (word !== '0) report_mismatch("pause_stop word after stop", 0, word);
            if (o_sram_addr !== '0) report_mismatch("pause_stop idle addr", 0, o_sram_addr);
        end
        end_test("pause_stop");
    endtask

    initial begin
        i_rst_n         = 1'b0;
        i_start         = 1'b0;
        i_pause         = 1'b0;
        i_stop          = 1'b0;
        i_fast          = 1'b1;
        i_interpolation = 1'b0;
        i_speed         = 4'd1;
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;

        test_reset();
        test_clocks();
        run_playback("normal_play", 1'b1, 4'd1, 1'b0, 5);
        run_playback("fast_speed4", 1'b1, 4'd4, 1'b0, 5);
        run_playback("slow_hold3", 1'b0, 4'd3, 1'b0, 9);
        run_playback("slow_linear2", 1'b0, 4'd2, 1'b1, 6);
        test_pause_stop();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: aud_player.f
verilog/aud_pkg.sv
verilog/aud_clk_gen.sv
verilog/aud_dsp.sv
verilog/aud_dac_serializer.sv
verilog/aud_top.sv
test/tb_sram_model.sv
test/tb_aud_top.sv
